// ==== source/rapid_recovery_pkg.sv ====
// Rapid recovery package with shared widths, register file depth and recovery states
package rapid_recovery_pkg;

  // Integer register file geometry
  // Matches the RV32 integer register file of the core
  localparam int unsigned RfDepth = 32;

  // Address width of one register file port
  localparam int unsigned RfAddrWidth = 5;

  // Width of registers, CSRs and the program counter
  localparam int unsigned DataWidth = 32;

  // Recovery controller states
  // IDLE     core runs normally, backup copies are updated
  // RESET    one cycle, setback and fetch lock are issued
  // HALT     waiting for the core to enter debug mode
  // RESTORE  saved state is streamed back to the core
  typedef enum logic [1:0] {
    IDLE    = 2'd0,
    RESET   = 2'd1,
    HALT    = 2'd2,
    RESTORE = 2'd3
  } recovery_mode_e;

endpackage

// ==== source/rr_address_generator.sv ====
// Restore address generator producing register file offsets and CSR indices
module rr_address_generator
  import rapid_recovery_pkg::*;
#(
  parameter int unsigned NumRfPorts = 2,
  parameter int unsigned NumCsr = 4,
  localparam int unsigned CsrIdWidth = (NumCsr > 1) ? $clog2(NumCsr) : 1
) (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   enable_i,
  output logic [RfAddrWidth-1:0] rf_offset_o,
  output logic                   rf_valid_o,
  output logic [CsrIdWidth-1:0]  csr_id_o,
  output logic                   csr_valid_o,
  output logic                   done_o
);

  // One extra bit so each counter can sit on its limit
  localparam int unsigned RfCntWidth = RfAddrWidth + 1;
  localparam int unsigned CsrCntWidth = CsrIdWidth + 1;

  // Offsets each port has to walk through
  localparam logic [RfCntWidth-1:0] RfLimit = RfCntWidth'(RfDepth / NumRfPorts);
  localparam logic [CsrCntWidth-1:0] CsrLimit = CsrCntWidth'(NumCsr);

  // The longer of the two sequences decides when restore is over
  localparam bit RfIsLonger = (RfDepth / NumRfPorts) >= NumCsr;

  logic [RfCntWidth-1:0]  rf_cnt_d, rf_cnt_q;
  logic [CsrCntWidth-1:0] csr_cnt_d, csr_cnt_q;

  // Counters still below their limits
  assign rf_valid_o  = rf_cnt_q < RfLimit;
  assign csr_valid_o = csr_cnt_q < CsrLimit;

  assign rf_offset_o = rf_cnt_q[RfAddrWidth-1:0];
  assign csr_id_o    = csr_cnt_q[CsrIdWidth-1:0];

  // Next counts, saturating at the limit and cleared when disabled
  always_comb begin
    rf_cnt_d  = '0;
    csr_cnt_d = '0;
    if (enable_i) begin
      rf_cnt_d  = rf_valid_o ? rf_cnt_q + 1'b1 : rf_cnt_q;
      csr_cnt_d = csr_valid_o ? csr_cnt_q + 1'b1 : csr_cnt_q;
    end
  end

  // Last count of the longer sequence is on the outputs
  if (RfIsLonger) begin : gen_done_rf
    assign done_o = enable_i & (rf_cnt_q == RfLimit - 1'b1);
  end else begin : gen_done_csr
    assign done_o = enable_i & (csr_cnt_q == CsrLimit - 1'b1);
  end

  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      rf_cnt_q  <= '0;
      csr_cnt_q <= '0;
    end else begin
      rf_cnt_q  <= rf_cnt_d;
      csr_cnt_q <= csr_cnt_d;
    end
  end

endmodule

// ==== source/rr_backup_regfile.sv ====
// Shadow integer register file, written from core write-back and read during restore
module rr_backup_regfile
  import rapid_recovery_pkg::*;
#(
  parameter int unsigned NumRfPorts = 2
) (
  input  logic                                    clk_i,
  input  logic                                    rst_ni,
  // Backup side, mirrors the core write-back port
  input  logic                                    backup_en_i,
  input  logic                                    we_i,
  input  logic [RfAddrWidth-1:0]                  waddr_i,
  input  logic [DataWidth-1:0]                    wdata_i,
  // Restore side, one read port per restore lane
  input  logic [NumRfPorts-1:0][RfAddrWidth-1:0]  raddr_i,
  output logic [NumRfPorts-1:0][DataWidth-1:0]    rdata_o
);

  // Shadow copies of the core registers
  logic [DataWidth-1:0] regs_q [RfDepth];

  // One-hot write decode
  logic [RfDepth-1:0] we_dec;

  // Writes only count while the controller allows backups
  logic wr_active;

  assign wr_active = backup_en_i & we_i;

  always_comb begin
    we_dec = '0;
    for (int unsigned r = 0; r < RfDepth; r++) begin
      if (waddr_i == RfAddrWidth'(r)) begin
        we_dec[r] = wr_active;
      end
    end
    // x0 is hardwired to zero in the core
    we_dec[0] = 1'b0;
  end

  // Storage update
  // Register 0 is cleared by reset and never written afterwards
  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      for (int unsigned r = 0; r < RfDepth; r++) begin
        regs_q[r] <= '0;
      end
    end else begin
      for (int unsigned r = 0; r < RfDepth; r++) begin
        if (we_dec[r]) begin
          regs_q[r] <= wdata_i;
        end
      end
    end
  end

  // Combinational read ports
  // Each restore lane sees its own slice of the file
  for (genvar p = 0; p < NumRfPorts; p++) begin : gen_rd_port
    assign rdata_o[p] = regs_q[raddr_i[p]];
  end

endmodule

// ==== source/rr_csr_pc_backup.sv ====
// Shadow CSR array and program counter, captured during backup and read back by index
module rr_csr_pc_backup
  import rapid_recovery_pkg::*;
#(
  parameter int unsigned NumCsr = 4,
  localparam int unsigned CsrIdWidth = (NumCsr > 1) ? $clog2(NumCsr) : 1
) (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  backup_en_i,
  // CSR backup port
  input  logic                  csr_we_i,
  input  logic [CsrIdWidth-1:0] csr_id_i,
  input  logic [DataWidth-1:0]  csr_wdata_i,
  // PC backup port
  input  logic                  pc_we_i,
  input  logic [DataWidth-1:0]  pc_i,
  // Restore read side
  input  logic [CsrIdWidth-1:0] csr_rid_i,
  output logic [DataWidth-1:0]  csr_rdata_o,
  output logic [DataWidth-1:0]  pc_o
);

  // Upper bound on ids, needed when NumCsr is not a power of two
  localparam logic [CsrIdWidth:0] CsrLimit = (CsrIdWidth + 1)'(NumCsr);

  logic [DataWidth-1:0] csrs_q [NumCsr];
  logic [DataWidth-1:0] pc_q;

  logic csr_wr_ok;
  logic csr_rd_ok;

  // Out of range ids are dropped on write and read as zero
  assign csr_wr_ok = backup_en_i & csr_we_i & ({1'b0, csr_id_i} < CsrLimit);
  assign csr_rd_ok = {1'b0, csr_rid_i} < CsrLimit;

  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      for (int unsigned c = 0; c < NumCsr; c++) begin
        csrs_q[c] <= '0;
      end
      pc_q <= '0;
    end else begin
      if (csr_wr_ok) begin
        csrs_q[csr_id_i] <= csr_wdata_i;
      end
      // PC follows the core only while backups run
      if (backup_en_i && pc_we_i) begin
        pc_q <= pc_i;
      end
    end
  end

  // Restore data, one CSR per cycle
  assign csr_rdata_o = csr_rd_ok ? csrs_q[csr_rid_i] : '0;

  // Saved PC is presented for the whole restore
  assign pc_o = pc_q;

endmodule

// ==== source/hmr_rapid_recovery_ctrl.sv ====
// Rapid recovery controller sequencing setback, debug halt, state restore and resume
module hmr_rapid_recovery_ctrl
  import rapid_recovery_pkg::*;
#(
  parameter int unsigned NumRfPorts = 2,
  parameter int unsigned NumCsr = 4,
  localparam int unsigned CsrIdWidth = (NumCsr > 1) ? $clog2(NumCsr) : 1
) (
  input  logic                                   clk_i,
  input  logic                                   rst_ni,
  // Recovery handshake
  input  logic                                   start_recovery_i,
  output logic                                   recovery_finished_o,
  // Core control
  output logic                                   setback_o,
  output logic                                   instr_lock_o,
  output logic                                   debug_req_o,
  input  logic                                   debug_halt_i,
  output logic                                   debug_resume_o,
  // Backup store control
  output logic                                   backup_enable_o,
  output logic                                   recover_csr_enable_o,
  output logic                                   recover_pc_enable_o,
  output logic                                   recover_rf_enable_o,
  // Restore write addressing
  output logic [NumRfPorts-1:0]                  rf_restore_we_o,
  output logic [NumRfPorts-1:0][RfAddrWidth-1:0] rf_restore_addr_o,
  output logic                                   csr_restore_we_o,
  output logic [CsrIdWidth-1:0]                  csr_id_o
);

  // Register file slice per restore port
  localparam int unsigned RfStride = RfDepth / NumRfPorts;

  recovery_mode_e rec_mode_d, rec_mode_q;

  logic instr_lock_d, instr_lock_q;
  logic setback_d, setback_q;

  logic                   addr_gen_done;
  logic [RfAddrWidth-1:0] rf_offset;
  logic                   rf_valid;
  logic                   csr_valid;

  // Walks offsets and ids while restore is active
  rr_address_generator #(
    .NumRfPorts (NumRfPorts),
    .NumCsr     (NumCsr)
  ) i_address_generator (
    .clk_i,
    .rst_ni,
    .enable_i    (recover_rf_enable_o),
    .rf_offset_o (rf_offset),
    .rf_valid_o  (rf_valid),
    .csr_id_o    (csr_id_o),
    .csr_valid_o (csr_valid),
    .done_o      (addr_gen_done)
  );

  // Each port restores its own contiguous slice
  for (genvar p = 0; p < NumRfPorts; p++) begin : gen_rf_port
    assign rf_restore_we_o[p]   = recover_rf_enable_o & rf_valid;
    assign rf_restore_addr_o[p] = RfAddrWidth'(p * RfStride) + rf_offset;
  end

  // CSRs go back one per cycle
  assign csr_restore_we_o = recover_csr_enable_o & csr_valid;

  assign setback_o    = setback_q;
  assign instr_lock_o = instr_lock_q;

  always_comb begin
    rec_mode_d           = rec_mode_q;
    instr_lock_d         = instr_lock_q;
    setback_d            = 1'b0;
    backup_enable_o      = 1'b0;
    debug_req_o          = 1'b0;
    debug_resume_o       = 1'b0;
    recovery_finished_o  = 1'b0;
    recover_csr_enable_o = 1'b0;
    recover_pc_enable_o  = 1'b0;
    recover_rf_enable_o  = 1'b0;

    unique case (rec_mode_q)
      IDLE: begin
        // Normal operation, keep shadow state current
        if (start_recovery_i) begin
          rec_mode_d = RESET;
        end else begin
          backup_enable_o = 1'b1;
        end
      end
      RESET: begin
        // Flush the core and block further fetches
        setback_d    = 1'b1;
        instr_lock_d = 1'b1;
        rec_mode_d   = HALT;
      end
      HALT: begin
        // Hold the request until the core reports halted
        debug_req_o = 1'b1;
        if (debug_halt_i) begin
          rec_mode_d = RESTORE;
        end
      end
      RESTORE: begin
        recover_csr_enable_o = 1'b1;
        recover_pc_enable_o  = 1'b1;
        recover_rf_enable_o  = 1'b1;
        // Last restore cycle, hand the core back
        if (addr_gen_done) begin
          instr_lock_d        = 1'b0;
          debug_resume_o      = 1'b1;
          recovery_finished_o = 1'b1;
          rec_mode_d          = IDLE;
        end
      end
      default: rec_mode_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      rec_mode_q   <= IDLE;
      instr_lock_q <= 1'b0;
      setback_q    <= 1'b0;
    end else begin
      rec_mode_q   <= rec_mode_d;
      instr_lock_q <= instr_lock_d;
      setback_q    <= setback_d;
    end
  end

endmodule

// ==== source/rapid_recovery_unit.sv ====
// Rapid recovery unit top, joining the controller with the shadow register, CSR and PC stores
module rapid_recovery_unit
  import rapid_recovery_pkg::*;
#(
  parameter int unsigned NumRfPorts = 2,
  parameter int unsigned NumCsr = 4,
  localparam int unsigned CsrIdWidth = (NumCsr > 1) ? $clog2(NumCsr) : 1
) (
  input  logic                                   clk_i,
  input  logic                                   rst_ni,
  // Recovery handshake
  input  logic                                   start_recovery_i,
  output logic                                   recovery_finished_o,
  // Core control
  output logic                                   setback_o,
  output logic                                   instr_lock_o,
  output logic                                   debug_req_o,
  input  logic                                   debug_halt_i,
  output logic                                   debug_resume_o,
  // Backup inputs from the core
  input  logic                                   core_rf_we_i,
  input  logic [RfAddrWidth-1:0]                 core_rf_waddr_i,
  input  logic [DataWidth-1:0]                   core_rf_wdata_i,
  input  logic                                   core_csr_we_i,
  input  logic [CsrIdWidth-1:0]                  core_csr_id_i,
  input  logic [DataWidth-1:0]                   core_csr_wdata_i,
  input  logic                                   core_pc_we_i,
  input  logic [DataWidth-1:0]                   core_pc_i,
  // Restore outputs to the core
  output logic [NumRfPorts-1:0]                  rf_restore_we_o,
  output logic [NumRfPorts-1:0][RfAddrWidth-1:0] rf_restore_addr_o,
  output logic [NumRfPorts-1:0][DataWidth-1:0]   rf_restore_data_o,
  output logic                                   csr_restore_we_o,
  output logic [CsrIdWidth-1:0]                  csr_restore_id_o,
  output logic [DataWidth-1:0]                   csr_restore_data_o,
  output logic                                   pc_restore_we_o,
  output logic [DataWidth-1:0]                   pc_restore_o
);

  logic backup_enable;

  // Sequencing and restore addressing
  hmr_rapid_recovery_ctrl #(
    .NumRfPorts (NumRfPorts),
    .NumCsr     (NumCsr)
  ) i_ctrl (
    .clk_i,
    .rst_ni,
    .start_recovery_i,
    .recovery_finished_o,
    .setback_o,
    .instr_lock_o,
    .debug_req_o,
    .debug_halt_i,
    .debug_resume_o,
    .backup_enable_o      (backup_enable),
    .recover_csr_enable_o (),
    .recover_pc_enable_o  (pc_restore_we_o),
    .recover_rf_enable_o  (),
    .rf_restore_we_o,
    .rf_restore_addr_o,
    .csr_restore_we_o,
    .csr_id_o             (csr_restore_id_o)
  );

  // Restore addresses double as read addresses
  rr_backup_regfile #(
    .NumRfPorts (NumRfPorts)
  ) i_backup_regfile (
    .clk_i,
    .rst_ni,
    .backup_en_i (backup_enable),
    .we_i        (core_rf_we_i),
    .waddr_i     (core_rf_waddr_i),
    .wdata_i     (core_rf_wdata_i),
    .raddr_i     (rf_restore_addr_o),
    .rdata_o     (rf_restore_data_o)
  );

  rr_csr_pc_backup #(
    .NumCsr (NumCsr)
  ) i_csr_pc_backup (
    .clk_i,
    .rst_ni,
    .backup_en_i (backup_enable),
    .csr_we_i    (core_csr_we_i),
    .csr_id_i    (core_csr_id_i),
    .csr_wdata_i (core_csr_wdata_i),
    .pc_we_i     (core_pc_we_i),
    .pc_i        (core_pc_i),
    .csr_rid_i   (csr_restore_id_o),
    .csr_rdata_o (csr_restore_data_o),
    .pc_o        (pc_restore_o)
  );

endmodule

// ==== sim/rapid_recovery_props.sv ====
// Concurrent assertions on the recovery controller outputs, bound into the controller
module rapid_recovery_props
  import rapid_recovery_pkg::*;
(
  input logic           clk_i,
  input logic           rst_ni,
  input recovery_mode_e rec_mode_q,
  input logic           setback_o,
  input logic           instr_lock_o,
  input logic           debug_req_o,
  input logic           debug_resume_o,
  input logic           recovery_finished_o,
  input logic           backup_enable_o,
  input logic           recover_csr_enable_o,
  input logic           recover_pc_enable_o,
  input logic           recover_rf_enable_o
);

  // Setback is a single pulse in the first HALT cycle
  assert property (@(posedge clk_i) disable iff (!rst_ni) setback_o |=> !setback_o)
    else $error("setback_o stayed high for more than one cycle");
  assert property (@(posedge clk_i) disable iff (!rst_ni) setback_o |-> rec_mode_q == HALT)
    else $error("setback_o high outside the first HALT cycle");

  // Resume only together with the finish pulse
  assert property (@(posedge clk_i) disable iff (!rst_ni) debug_resume_o |-> recovery_finished_o)
    else $error("debug_resume_o without recovery_finished_o");

  // Backups stop while any restore path is active
  assert property (@(posedge clk_i) disable iff (!rst_ni)
      backup_enable_o |-> !(recover_csr_enable_o || recover_pc_enable_o || recover_rf_enable_o))
    else $error("backup_enable_o overlaps a recover enable");

  // Halt request only behind the fetch lock
  assert property (@(posedge clk_i) disable iff (!rst_ni) debug_req_o |-> instr_lock_o)
    else $error("debug_req_o high while instr_lock_o is low");

endmodule

bind hmr_rapid_recovery_ctrl rapid_recovery_props i_props (
  .clk_i,
  .rst_ni,
  .rec_mode_q,
  .setback_o,
  .instr_lock_o,
  .debug_req_o,
  .debug_resume_o,
  .recovery_finished_o,
  .backup_enable_o,
  .recover_csr_enable_o,
  .recover_pc_enable_o,
  .recover_rf_enable_o
);

// ==== sim/rapid_recovery_tb.sv ====
// Directed testbench for the rapid recovery unit, checking restore data against a shadow model
module rapid_recovery_tb
  import rapid_recovery_pkg::*;
();

  localparam int unsigned NumRfPorts = 2;
  localparam int unsigned NumCsr = 4;
  localparam int unsigned CsrIdWidth = 2;
  localparam int unsigned RfStride = RfDepth / NumRfPorts;
  // Longer of the RF and CSR sequences sets the restore length
  localparam int unsigned RestoreCycles = (RfStride > NumCsr) ? RfStride : NumCsr;
  // All tests together need roughly 300 cycles
  localparam int unsigned TimeoutCycles = 2000;

  logic clk_i = 1'b0;
  logic rst_ni;
  logic start_recovery_i;
  logic debug_halt_i;
  logic core_rf_we_i;
  logic [RfAddrWidth-1:0] core_rf_waddr_i;
  logic [DataWidth-1:0] core_rf_wdata_i;
  logic core_csr_we_i;
  logic [CsrIdWidth-1:0] core_csr_id_i;
  logic [DataWidth-1:0] core_csr_wdata_i;
  logic core_pc_we_i;
  logic [DataWidth-1:0] core_pc_i;

  logic recovery_finished_o;
  logic setback_o;
  logic instr_lock_o;
  logic debug_req_o;
  logic debug_resume_o;
  logic [NumRfPorts-1:0] rf_restore_we_o;
  logic [NumRfPorts-1:0][RfAddrWidth-1:0] rf_restore_addr_o;
  logic [NumRfPorts-1:0][DataWidth-1:0] rf_restore_data_o;
  logic csr_restore_we_o;
  logic [CsrIdWidth-1:0] csr_restore_id_o;
  logic [DataWidth-1:0] csr_restore_data_o;
  logic pc_restore_we_o;
  logic [DataWidth-1:0] pc_restore_o;

  // Expected shadow state
  logic [DataWidth-1:0] rf_model [RfDepth];
  logic [DataWidth-1:0] csr_model [NumCsr];
  logic [DataWidth-1:0] pc_model;

  integer seed = 32'hd725_8e64;
  int unsigned cycle_cnt = 0;

  rapid_recovery_unit #(
    .NumRfPorts (NumRfPorts),
    .NumCsr     (NumCsr)
  ) rapid_recovery_unit_i (.*);

  always #20 clk_i = ~clk_i;

  // Run limit
  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TimeoutCycles) begin
      $display("Timeout: the run did not end within %0d cycles", TimeoutCycles);
      $display("SIMULATION FAILED");
      $fatal(1, "run stopped by the cycle limit");
    end
  end

  task automatic check_data(input string name, input logic [DataWidth-1:0] exp,
                            input logic [DataWidth-1:0] act);
    if (act !== exp) begin
      $display("mismatch in %s: expected %h, actual %h", name, exp, act);
      $display("SIMULATION FAILED");
      $fatal(1, "data compare failed");
    end
  endtask

  task automatic check_addr(input string name, input logic [RfAddrWidth-1:0] exp,
                            input logic [RfAddrWidth-1:0] act);
    if (act !== exp) begin
      $display("mismatch in %s: expected %0d, actual %0d", name, exp, act);
      $display("SIMULATION FAILED");
      $fatal(1, "address compare failed");
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("mismatch in %s: expected %b, actual %b", name, exp, act);
      $display("SIMULATION FAILED");
      $fatal(1, "control compare failed");
    end
  endtask

  task automatic stop_core_writes();
    core_rf_we_i  <= 1'b0;
    core_csr_we_i <= 1'b0;
    core_pc_we_i  <= 1'b0;
  endtask

  // All control outputs and restore enables low
  task automatic check_quiet(input string name);
    check_bit({name, " setback"}, 1'b0, setback_o);
    check_bit({name, " instr_lock"}, 1'b0, instr_lock_o);
    check_bit({name, " debug_req"}, 1'b0, debug_req_o);
    check_bit({name, " finished"}, 1'b0, recovery_finished_o);
    check_bit({name, " resume"}, 1'b0, debug_resume_o);
    check_bit({name, " rf_we"}, 1'b0, |rf_restore_we_o);
    check_bit({name, " csr_we"}, 1'b0, csr_restore_we_o);
    check_bit({name, " pc_we"}, 1'b0, pc_restore_we_o);
  endtask

  // Called on a rising edge, leaves on the edge that enters RESTORE
  task automatic enter_halt(input string name, input int unsigned halt_wait);
    start_recovery_i <= 1'b1;
    // Edge that samples the request in IDLE
    @(posedge clk_i);
    start_recovery_i <= 1'b0;
    @(negedge clk_i);
    check_quiet({name, " reset cycle"});
    @(negedge clk_i);
    check_bit({name, " setback"}, 1'b1, setback_o);
    check_bit({name, " instr_lock"}, 1'b1, instr_lock_o);
    check_bit({name, " debug_req"}, 1'b1, debug_req_o);
    // Core has not halted yet
    repeat (halt_wait) begin
      @(negedge clk_i);
      check_bit({name, " setback width"}, 1'b0, setback_o);
      check_bit({name, " instr_lock"}, 1'b1, instr_lock_o);
      check_bit({name, " debug_req held"}, 1'b1, debug_req_o);
      check_bit({name, " early rf_we"}, 1'b0, |rf_restore_we_o);
      check_bit({name, " early csr_we"}, 1'b0, csr_restore_we_o);
    end
    @(posedge clk_i);
    debug_halt_i <= 1'b1;
    @(posedge clk_i);
    debug_halt_i <= 1'b0;
  endtask

  // Follows RESTORE until the finish pulse, comparing every write
  task automatic run_restore(input string name);
    int unsigned cyc;
    logic [RfAddrWidth-1:0] exp_addr;
    cyc = 0;
    do begin
      @(negedge clk_i);
      cyc++;
      check_bit({name, " instr_lock"}, 1'b1, instr_lock_o);
      check_bit({name, " pc_we"}, 1'b1, pc_restore_we_o);
      check_data({name, " pc"}, pc_model, pc_restore_o);
      // Port p walks its own slice from offset zero
      for (int p = 0; p < NumRfPorts; p++) begin
        check_bit({name, " rf_we"}, cyc <= RfStride, rf_restore_we_o[p]);
        if (cyc <= RfStride) begin
          exp_addr = RfAddrWidth'(p * RfStride + cyc - 1);
          check_addr({name, " rf_addr"}, exp_addr, rf_restore_addr_o[p]);
          check_data({name, " rf_data"}, rf_model[exp_addr], rf_restore_data_o[p]);
        end
      end
      check_bit({name, " csr_we"}, cyc <= NumCsr, csr_restore_we_o);
      if (cyc <= NumCsr) begin
        check_addr({name, " csr_id"}, RfAddrWidth'(cyc - 1), RfAddrWidth'(csr_restore_id_o));
        check_data({name, " csr_data"}, csr_model[cyc - 1], csr_restore_data_o);
      end
      check_bit({name, " finished"}, cyc == RestoreCycles, recovery_finished_o);
      check_bit({name, " resume"}, cyc == RestoreCycles, debug_resume_o);
    end while (!recovery_finished_o);
    // Lock drops one cycle after the pulse
    @(negedge clk_i);
    check_quiet({name, " after restore"});
  endtask

  task automatic test_reset();
    check_quiet("test_reset");
    check_data("test_reset pc", '0, pc_restore_o);
    repeat (5) @(negedge clk_i);
    check_quiet("test_reset idle");
  endtask

  task automatic test_entry_sequence();
    int unsigned halt_wait;
    halt_wait = 3 + ($unsigned($random(seed)) % 8);
    @(posedge clk_i);
    enter_halt("test_entry_sequence", halt_wait);
    run_restore("test_entry_sequence");
  endtask

  task automatic test_rf_restore();
    logic [DataWidth-1:0] value;
    // x0 is written too, the shadow copy must keep it at zero
    for (int r = 0; r < RfDepth; r++) begin
      value = $random(seed);
      @(posedge clk_i);
      core_rf_we_i    <= 1'b1;
      core_rf_waddr_i <= RfAddrWidth'(r);
      core_rf_wdata_i <= value;
      if (r != 0) begin
        rf_model[r] = value;
      end
    end
    @(posedge clk_i);
    stop_core_writes();
    enter_halt("test_rf_restore", 2);
    run_restore("test_rf_restore");
  endtask

  task automatic test_csr_pc_restore();
    logic [DataWidth-1:0] value;
    for (int c = 0; c < NumCsr; c++) begin
      value = $random(seed);
      @(posedge clk_i);
      core_csr_we_i    <= 1'b1;
      core_csr_id_i    <= CsrIdWidth'(c);
      core_csr_wdata_i <= value;
      csr_model[c] = value;
    end
    value = $random(seed);
    @(posedge clk_i);
    core_csr_we_i <= 1'b0;
    core_pc_we_i  <= 1'b1;
    core_pc_i     <= value;
    pc_model = value;
    @(posedge clk_i);
    stop_core_writes();
    enter_halt("test_csr_pc_restore", 4);
    run_restore("test_csr_pc_restore");
  endtask

  task automatic test_finish_and_no_capture();
    // Conflicting core writes from the request edge through HALT
    @(posedge clk_i);
    core_rf_we_i     <= 1'b1;
    core_rf_waddr_i  <= RfAddrWidth'(7);
    core_rf_wdata_i  <= ~rf_model[7];
    core_csr_we_i    <= 1'b1;
    core_csr_id_i    <= CsrIdWidth'(2);
    core_csr_wdata_i <= ~csr_model[2];
    core_pc_we_i     <= 1'b1;
    core_pc_i        <= ~pc_model;
    enter_halt("test_finish_and_no_capture", 3);
    stop_core_writes();
    run_restore("test_finish_and_no_capture");
    // Second pass must still see the state from before the first
    @(posedge clk_i);
    enter_halt("test_finish_and_no_capture second", 1);
    run_restore("test_finish_and_no_capture second");
  endtask

  initial begin
    rst_ni           = 1'b0;
    start_recovery_i = 1'b0;
    debug_halt_i     = 1'b0;
    core_rf_we_i     = 1'b0;
    core_rf_waddr_i  = '0;
    core_rf_wdata_i  = '0;
    core_csr_we_i    = 1'b0;
    core_csr_id_i    = '0;
    core_csr_wdata_i = '0;
    core_pc_we_i     = 1'b0;
    core_pc_i        = '0;
    for (int r = 0; r < RfDepth; r++) begin
      rf_model[r] = '0;
    end
    for (int c = 0; c < NumCsr; c++) begin
      csr_model[c] = '0;
    end
    pc_model = '0;
    repeat (5) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(negedge clk_i);
    test_reset();
    test_entry_sequence();
    test_rf_restore();
    test_csr_pc_restore();
    test_finish_and_no_capture();
    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

// ==== verilog.f ====
source/rapid_recovery_pkg.sv
source/rr_address_generator.sv
source/rr_backup_regfile.sv
source/rr_csr_pc_backup.sv
source/hmr_rapid_recovery_ctrl.sv
source/rapid_recovery_unit.sv
sim/rapid_recovery_props.sv
sim/rapid_recovery_tb.sv

// ==== Makefile ====
TOP := rapid_recovery_tb

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f verilog.f -o V$(TOP)
	./obj_dir/V$(TOP) > sim.log 2>&1; cat sim.log
	@if grep -q "SIMULATION FAILED" sim.log || ! grep -q "SIMULATION PASSED" sim.log; then \
		echo "Simulation failed, see sim.log"; exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log
